//--- soqpskDemod.f
hw/soqpskPkg.sv
hw/symbolControl.sv
hw/branchMetric.sv
hw/acsSoqpsk.sv
hw/traceBackSoqpsk.sv
hw/soqpskDetector.sv
testbench/soqpskDetector_assertions.sv
testbench/soqpskDetectorTb.sv

//--- testbench/soqpskDetectorTb.sv
// self-checking against differential hard bits with samples of +/-96 and |noise| < 64 clipped to 8 bits
`timescale 1ns/1ps

module soqpskDetectorTb;

   logic                                  clk = 1'b0;
   logic                                  reset;
   logic signed [soqpskPkg::SAMPLE_W-1:0] sample;
   logic                                  sampleValid;
   logic                                  dataBit;
   logic                                  bitValid;

   // reference model cleared while reset is high
   logic        sentBits [$];       // one entry per strobe since reset
   int          strobeCount = 0;
   int          outCount = 0;       // valid outputs since reset
   logic        firstOutSeen = 1'b0;
   logic        prevStrobe = 1'b0;
   logic        prevReset = 1'b0;
   int          checkCount = 0;
   int          errorCount = 0;
   int unsigned lcgState = 16;

   // test lengths in symbols
   int          acqLen = 20;
   int          cleanLen = 200;
   int          gapLen = 200;
   int          noiseLen = 2000;
   int          preResetLen = 31;   // odd so the phase is 1 when reset hits
   int          postResetLen = 40;
   int          maxGap = 5;         // upper bound of idle cycles between strobes

   always #20 clk = ~clk;  // 40 ns

   soqpskDetector i_soqpskDetector (
      .clk         (clk),
      .reset       (reset),
      .sample      (sample),
      .sampleValid (sampleValid),
      .dataBit     (dataBit),
      .bitValid    (bitValid)
   );

   bind soqpskDetector soqpskDetector_assertions i_assertions (
      .clk         (clk),
      .reset       (reset),
      .sampleValid (sampleValid),
      .bitValid    (bitValid),
      .ctrlState   (i_symbolControl.state),
      .timing      (timing),
      .pathMetric  (i_acsSoqpsk.pathMetric)
   );

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic int unsigned nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState >> 8;  // low bits of an LCG cycle fast
   endfunction

   function automatic int totalErrors();
      return errorCount + i_soqpskDetector.i_assertions.failCount;
   endfunction

   task automatic applyReset();
      @(posedge clk);
      reset       <= 1'b1;
      sampleValid <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   endtask

   // one strobe followed by gap idle cycles
   task automatic sendSymbol(input logic b, input bit noisy, input int gap);
      int level;
      level = b ? 96 : -96;
      if (noisy) level = level + int'(nextRandom() % 127) - 63;  // |noise| < 64
      if (level > 127) level = 127;     // clip to the sample width
      if (level < -128) level = -128;
      @(posedge clk);
      sample      <= level[soqpskPkg::SAMPLE_W-1:0];
      sampleValid <= 1'b1;
      sentBits.push_back(b);
      repeat (gap) begin
         @(posedge clk);
         sampleValid <= 1'b0;
      end
   endtask

   task automatic sendStream(input int count, input int gapMax, input bit noisy);
      logic b;
      int   gap;
      for (int i = 0; i < count; i++) begin
         b   = (nextRandom() & 32'd1) != 0;
         gap = (gapMax > 0) ? int'(nextRandom() % (gapMax + 1)) : 0;
         sendSymbol(b, noisy, gap);
      end
   endtask

   task automatic idleInputs();
      @(posedge clk);
      sampleValid <= 1'b0;
   endtask

   // strobes keep coming while reset is held
   task automatic resetDuringStream();
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         reset       <= 1'b1;
         sampleValid <= 1'b1;
         sample      <= nextRandom() % 256;
      end
      @(posedge clk);
      reset       <= 1'b0;
      sampleValid <= 1'b0;
   endtask

   task automatic waitOutputs(input int target);
      while (outCount < target) @(posedge clk);
      repeat (2) @(posedge clk);  // one-cycle latency so nothing may trail
      assert (outCount == target) else begin
         $display("mismatch at %0t: %0d outputs, expected %0d", $time, outCount, target);
         errorCount++;
      end
   endtask

   task automatic reportTest(input string name, input int checks0, input int errors0);
      int errs;
      errs = totalErrors() - errors0;
      $display("test %s: %0d outputs checked, %0d errors, %s", name,
               checkCount - checks0, errs, (errs == 0) ? "ok" : "FAILED");
   endtask

   // ----------------------------------------
   // output checker
   // ----------------------------------------
   task automatic checkOutput();
      logic expected;
      assert (prevStrobe) else begin
         $display("bitValid at %0t came without a strobe in the cycle before", $time);
         errorCount++;
      end
      if (!firstOutSeen) begin
         assert (strobeCount == soqpskPkg::ACQ_SYMBOLS) else begin
            $display("mismatch at %0t: first output after %0d strobes, expected %0d",
                     $time, strobeCount, soqpskPkg::ACQ_SYMBOLS);
            errorCount++;
         end
         firstOutSeen = 1'b1;
      end
      // output k is sent bit k+ACQ-2 xor the bit two symbols earlier
      expected = sentBits[outCount + soqpskPkg::ACQ_SYMBOLS - 2] ^
                 sentBits[outCount + soqpskPkg::ACQ_SYMBOLS - 4];
      assert (dataBit === expected) else begin
         $display("mismatch at %0t: output %0d is %b, expected %b",
                  $time, outCount, dataBit, expected);
         errorCount++;
      end
      checkCount++;
      outCount++;
   endtask

   always @(negedge clk) begin   // mid-cycle where outputs are settled
      if (reset) begin
         if (prevReset) begin
            assert (!bitValid) else begin
               $display("bitValid still pulsing at %0t while reset is held", $time);
               errorCount++;
            end
         end
         sentBits.delete();
         strobeCount  = 0;
         outCount     = 0;
         firstOutSeen = 1'b0;
      end else begin
         if (bitValid) checkOutput();
         if (sampleValid) strobeCount++;
      end
      prevStrobe = sampleValid && !reset;
      prevReset  = reset;
   end

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic runStreamTest(input string name, input int count, input int gapMax,
                                input bit noisy);
      int checks0;
      int errors0;
      checks0 = checkCount;
      errors0 = totalErrors();
      applyReset();
      sendStream(count, gapMax, noisy);
      idleInputs();
      waitOutputs(count - soqpskPkg::ACQ_SYMBOLS + 1);
      reportTest(name, checks0, errors0);
   endtask

   task automatic resetMidRunTest();
      int checks0;
      int errors0;
      checks0 = checkCount;
      errors0 = totalErrors();
      applyReset();
      sendStream(preResetLen, 0, 1'b0);
      resetDuringStream();
      @(negedge clk);
      assert (i_soqpskDetector.timing.symEnEven == 1'b0 &&
              i_soqpskDetector.i_symbolControl.state == soqpskPkg::IDLE) else begin
         $display("phase or control FSM did not restart after reset at %0t", $time);
         errorCount++;
      end
      sendStream(postResetLen, 0, 1'b0);
      idleInputs();
      waitOutputs(postResetLen - soqpskPkg::ACQ_SYMBOLS + 1);
      reportTest("reset mid-run", checks0, errors0);
   endtask

   initial begin
      reset       = 1'b1;
      sampleValid = 1'b0;
      sample      = '0;
      runStreamTest("acquisition", acqLen, 0, 1'b0);
      runStreamTest("noise-free stream", cleanLen, 0, 1'b0);
      runStreamTest("idle gaps", gapLen, maxGap, 1'b0);
      runStreamTest("bounded noise", noiseLen, 0, 1'b1);
      resetMidRunTest();
      $display("5 tests, %0d outputs checked, %0d errors", checkCount, totalErrors());
      if (totalErrors() == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog allowing every symbol the widest gap plus slack
   initial begin
      int limitCycles;
      limitCycles = (acqLen + cleanLen + gapLen + noiseLen + preResetLen + 4 +
                     postResetLen) * maxGap + 100;
      repeat (limitCycles) @(posedge clk);
      $display("timeout: the run did not finish within %0d clock cycles", limitCycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- testbench/soqpskDetector_assertions.sv
// bound into soqpskDetector, posedge sampled, needs a simulator with bind and concurrent assertions
`timescale 1ns/1ps

module soqpskDetector_assertions (
   input logic                                  clk,
   input logic                                  reset,
   input logic                                  sampleValid,
   input logic                                  bitValid,
   input soqpskPkg::ctrlState_t                 ctrlState,
   input soqpskPkg::symTiming_t                 timing,
   input logic signed [soqpskPkg::METRIC_W-1:0] pathMetric [soqpskPkg::NUM_STATES]
);

   int   failCount = 0;   // failed assertions so far
   logic metricsInRange;  // all four metrics strictly inside the signed range

   // ----------------------------------------
   // output strobe
   // ----------------------------------------
   // one cycle after the strobe, never on its own
   strobeFollowsSample: assert property (@(posedge clk) disable iff (reset)
      bitValid |-> $past(sampleValid))
      else begin
         $error("bitValid without sampleValid in the cycle before");
         failCount++;
      end

   strobeOnlyInTrack: assert property (@(posedge clk) disable iff (reset)
      bitValid |-> (ctrlState == soqpskPkg::TRACK))
      else begin
         $error("bitValid while the control FSM is not in TRACK");
         failCount++;
      end

   // reset clears the strobe register on the next edge
   strobeLowInReset: assert property (@(posedge clk)
      reset |=> !bitValid)
      else begin
         $error("bitValid high after reset was applied");
         failCount++;
      end

   // ----------------------------------------
   // phase
   // ----------------------------------------
   phaseTogglesOnSymbol: assert property (@(posedge clk) disable iff (reset)
      (timing.symEn && !reset) |=> (timing.symEnEven != $past(timing.symEnEven)))
      else begin
         $error("phase did not toggle on a symbol strobe");
         failCount++;
      end

   phaseHoldsWhenIdle: assert property (@(posedge clk) disable iff (reset)
      (!timing.symEn && !reset) |=> $stable(timing.symEnEven))
      else begin
         $error("phase changed without a symbol strobe");
         failCount++;
      end

   // ----------------------------------------
   // metric range
   // ----------------------------------------
   always_comb begin
      metricsInRange = 1'b1;
      for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
         if ((pathMetric[s] >= (2 ** (soqpskPkg::METRIC_W - 1)) - 1) ||
             (pathMetric[s] <= -(2 ** (soqpskPkg::METRIC_W - 1)))) begin
            metricsInRange = 1'b0;  // touching the limit means normalization broke
         end
      end
   end

   metricsBounded: assert property (@(posedge clk) metricsInRange)
      else begin
         $error("a path metric reached the signed limit of its width");
         failCount++;
      end

endmodule

//--- hw/soqpskDetector.sv
// SOQPSK hard-decision detector top, differential bits, every sampleValid strobe must be taken
`timescale 1ns/1ps

module soqpskDetector (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic signed [soqpskPkg::SAMPLE_W-1:0] sample,
   input  logic                                 sampleValid,
   output logic                                 dataBit,
   output logic                                 bitValid
);

   // ----------------------------------------
   // internal buses
   // ----------------------------------------
   soqpskPkg::symTiming_t timing;    // strobe, phase, track
   soqpskPkg::branchSet_t branches;  // combinational, this symbol
   soqpskPkg::survivor_t  surv;      // registered, cycle after symEn
   logic                  decision;  // raw trace-back output

   // timing, acquisition, output qualify
   symbolControl i_symbolControl (
      .clk         (clk),
      .reset       (reset),
      .sampleValid (sampleValid),
      .decision    (decision),
      .timing      (timing),
      .dataBit     (dataBit),
      .bitValid    (bitValid)
   );

   // sample to per-state scores
   branchMetric i_branchMetric (
      .sample   (sample),
      .timing   (timing),
      .branches (branches)
   );

   // path metrics and survivors
   acsSoqpsk i_acsSoqpsk (
      .clk      (clk),
      .reset    (reset),
      .timing   (timing),
      .branches (branches),
      .surv     (surv)
   );

   // one step back to the decision
   traceBackSoqpsk i_traceBackSoqpsk (
      .clk      (clk),
      .reset    (reset),
      .timing   (timing),
      .surv     (surv),
      .decision (decision)
   );

endmodule

//--- hw/traceBackSoqpsk.sv
// single-step trace-back, differential output (bit XOR bit two back), valid the cycle after symEn
`timescale 1ns/1ps

module traceBackSoqpsk (
   input  logic                   clk,
   input  logic                   reset,
   input  soqpskPkg::symTiming_t  timing,
   input  soqpskPkg::survivor_t   surv,
   output logic                   decision
);

   logic [soqpskPkg::NUM_STATES-1:0] selDly;     // selects of the previous symbol
   logic [soqpskPkg::STATE_W-1:0]    curState;
   logic [soqpskPkg::STATE_W-1:0]    prevState;  // one step back
   logic                             curSel;

   // ----------------------------------------
   // step back from the best state
   // ----------------------------------------
   // phase has already toggled in the decision cycle,
   // so symEnEven = 1 here means the scored symbol was odd
   always_comb begin
      curState = surv.index;
      curSel   = surv.sel[curState];
      if (!curSel) begin
         prevState = curState;                // came from itself
      end else if (timing.symEnEven) begin
         prevState = curState ^ 2'b01;        // odd symbol, bit0 flipped
      end else begin
         prevState = curState ^ 2'b10;        // even symbol, bit1 flipped
      end
   end

   // ----------------------------------------
   // select history, one generation
   // ----------------------------------------
   // captures the survivor still held from the last symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         selDly <= '0;
      end else if (timing.symEn) begin
         selDly <= surv.sel;
      end
   end

   assign decision = selDly[prevState];  // 1 = bit differs from two back

endmodule

//--- hw/acsSoqpsk.sv
// four-state ACS, metrics normalized to state 0 each symbol, ties keep the unflipped predecessor
`timescale 1ns/1ps

module acsSoqpsk (
   input  logic                   clk,
   input  logic                   reset,
   input  soqpskPkg::symTiming_t  timing,
   input  soqpskPkg::branchSet_t  branches,
   output soqpskPkg::survivor_t   surv
);

   logic signed [soqpskPkg::METRIC_W-1:0] pathMetric [soqpskPkg::NUM_STATES];
   logic signed [soqpskPkg::METRIC_W-1:0] newMetric  [soqpskPkg::NUM_STATES];
   logic signed [soqpskPkg::METRIC_W-1:0] normMetric [soqpskPkg::NUM_STATES];
   logic signed [soqpskPkg::METRIC_W-1:0] keepMetric;  // predecessor only, no self
   logic signed [soqpskPkg::METRIC_W-1:0] flipMetric;
   logic [soqpskPkg::NUM_STATES-1:0]      selNext;
   logic [soqpskPkg::STATE_W-1:0]         flipMask;
   logic                                  best01;      // winner of states 0/1
   logic                                  best23;      // winner of states 2/3, offset 2
   logic [soqpskPkg::STATE_W-1:0]         bestIndex;

   // ----------------------------------------
   // add-compare-select
   // ----------------------------------------
   // the bit being overwritten is the one that differs between predecessors
   assign flipMask = timing.symEnEven ? 2'b10 : 2'b01;

   always_comb begin
      keepMetric = '0;
      flipMetric = '0;
      for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
         keepMetric = pathMetric[s];
         flipMetric = pathMetric[2'(s) ^ flipMask];
         selNext[s] = (flipMetric > keepMetric);  // strict, ties unflipped
         if (selNext[s]) begin
            newMetric[s] = flipMetric + $signed(branches.bm[s]);
         end else begin
            newMetric[s] = keepMetric + $signed(branches.bm[s]);
         end
      end
   end

   // ----------------------------------------
   // best state, two-level compare tree
   // ----------------------------------------
   always_comb begin
      best01 = (newMetric[1] > newMetric[0]);
      best23 = (newMetric[3] > newMetric[2]);
      // pair winners against each other, ties to the lower pair
      if (newMetric[{1'b1, best23}] > newMetric[{1'b0, best01}]) begin
         bestIndex = {1'b1, best23};
      end else begin
         bestIndex = {1'b0, best01};
      end
   end

   // ----------------------------------------
   // normalization
   // ----------------------------------------
   // spread stays within a few branch metrics, so 12 bits hold it
   always_comb begin
      for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
         normMetric[s] = newMetric[s] - newMetric[0];
      end
   end

   // ----------------------------------------
   // registers, update on symbol strobe
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
            pathMetric[s] <= '0;
         end
         surv <= '0;
      end else if (timing.symEn) begin
         for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
            pathMetric[s] <= normMetric[s];
         end
         surv.sel   <= selNext;
         surv.index <= bestIndex;  // argmax of pre-normalized metrics
      end
   end

endmodule

//--- hw/branchMetric.sv
// combinational branch metrics, hard +/- correlation of the sample, no channel scaling
`timescale 1ns/1ps

module branchMetric (
   input  logic signed [soqpskPkg::SAMPLE_W-1:0] sample,
   input  soqpskPkg::symTiming_t                 timing,
   output soqpskPkg::branchSet_t                 branches
);

   // ----------------------------------------
   // widened sample and its negation
   // ----------------------------------------
   logic signed [soqpskPkg::BRANCH_W-1:0] extSample;
   logic signed [soqpskPkg::BRANCH_W-1:0] negSample;
   logic [soqpskPkg::NUM_STATES-1:0]      newBit;  // bit written this phase, per state

   assign extSample = {sample[soqpskPkg::SAMPLE_W-1], sample};  // sign extend
   assign negSample = -extSample;  // -(-128) = +128 fits in 9 bits

   // ----------------------------------------
   // per-state bit select
   // ----------------------------------------
   // odd symbol writes bit0, even writes bit1
   always_comb begin
      for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
         newBit[s] = timing.symEnEven ? s[1] : s[0];
      end
   end

   // ----------------------------------------
   // metric per state
   // ----------------------------------------
   always_comb begin
      for (int s = 0; s < soqpskPkg::NUM_STATES; s++) begin
         if (newBit[s]) begin
            branches.bm[s] = extSample;   // hypothesis 1, reward positive
         end else begin
            branches.bm[s] = negSample;   // hypothesis 0, reward negative
         end
      end
   end

endmodule

//--- hw/symbolControl.sv
// symbol timing and output qualify; assumes at most one sampleValid per cycle, bit held between strobes
`timescale 1ns/1ps

module symbolControl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sampleValid,
   input  logic                   decision,   // from trace-back, valid cycle after strobe
   output soqpskPkg::symTiming_t  timing,
   output logic                   dataBit,
   output logic                   bitValid
);

   soqpskPkg::ctrlState_t               state;
   logic [soqpskPkg::ACQ_CNT_W-1:0]     symCount;   // strobes seen while acquiring
   logic                                symEnEven;
   logic                                lastAcq;    // strobe that completes acquisition
   logic                                lastBit;    // held decision

   // ----------------------------------------
   // timing out to the datapath
   // ----------------------------------------
   always_comb begin
      timing.symEn     = sampleValid;
      timing.symEnEven = symEnEven;
      timing.track     = (state == soqpskPkg::TRACK);
   end

   // 8th strobe already qualifies, its output lands as TRACK begins
   always_comb begin
      lastAcq = sampleValid && (state == soqpskPkg::ACQUIRE) &&
                (symCount == soqpskPkg::ACQ_LAST);
   end

   // ----------------------------------------
   // FSM, phase, output strobe
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= soqpskPkg::IDLE;
         symCount  <= '0;
         symEnEven <= 1'b0;  // first symbol is odd
         bitValid  <= 1'b0;
         lastBit   <= 1'b0;
      end else begin
         bitValid <= sampleValid && ((state == soqpskPkg::TRACK) || lastAcq);
         if (sampleValid) symEnEven <= ~symEnEven;  // toggle per symbol
         if (bitValid) lastBit <= decision;         // keep for idle cycles
         case (state)
            soqpskPkg::IDLE: begin
               if (sampleValid) begin
                  symCount <= symCount + 1'b1;      // first strobe counts
                  state    <= soqpskPkg::ACQUIRE;
               end
            end
            soqpskPkg::ACQUIRE: begin
               if (lastAcq) begin
                  symCount <= '0;
                  state    <= soqpskPkg::TRACK;
               end else if (sampleValid) begin
                  symCount <= symCount + 1'b1;
               end
            end
            soqpskPkg::TRACK: state <= soqpskPkg::TRACK;  // until reset
            default: state <= soqpskPkg::IDLE;
         endcase
      end
   end

   // live decision on the strobe cycle, last one otherwise
   assign dataBit = bitValid ? decision : lastBit;

endmodule

//--- hw/soqpskPkg.sv
// shared types for the 4-state SOQPSK detector, hard decisions only, no back-pressure on samples
package soqpskPkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int SAMPLE_W = 8;             // signed soft sample
   localparam int BRANCH_W = SAMPLE_W + 1;  // room for -(-128)
   localparam int METRIC_W = 12;            // path metric, normalized each symbol
   localparam int NUM_STATES = 4;
   localparam int STATE_W = 2;              // bit0 written on odd, bit1 on even

   // symbols after reset before output counts as valid
   // metric settling plus the two-symbol trace-back lag
   localparam int ACQ_SYMBOLS = 8;
   localparam int ACQ_CNT_W = $clog2(ACQ_SYMBOLS);
   localparam logic [ACQ_CNT_W-1:0] ACQ_LAST = ACQ_CNT_W'(ACQ_SYMBOLS - 1);

   // ----------------------------------------
   // control
   // ----------------------------------------
   typedef enum logic [1:0] {
      IDLE,     // nothing seen since reset
      ACQUIRE,  // metrics settling
      TRACK     // decisions valid
   } ctrlState_t;

   typedef struct packed {
      logic symEn;      // one per symbol
      logic symEnEven;  // phase of the current symbol, 0 = odd
      logic track;      // acquisition done
   } symTiming_t;

   // ----------------------------------------
   // datapath bundles
   // ----------------------------------------
   typedef struct packed {
      logic [NUM_STATES-1:0][BRANCH_W-1:0] bm;  // signed, one per state
   } branchSet_t;

   typedef struct packed {
      logic [NUM_STATES-1:0] sel;  // 1 = flipped-phase predecessor won
      logic [STATE_W-1:0]    index;  // best state
   } survivor_t;

endpackage
